/* cpu.f */
logic/cpuPkg.sv
logic/pipelineBarrier.sv
logic/registerFile.sv
logic/hazardUnit.sv
logic/decoder.sv
logic/executeUnit.sv
logic/memoryUnit.sv
logic/cpu.sv
dv/cpuTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = cpuTb
FILELIST = cpu.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "Simulation gave no result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

  localparam int resetCycles = 16;
  localparam int runCycles = 40;
  localparam int numRuns = 9;
  // Every run is a reset phase plus a fixed run phase
  localparam int timeoutLimit = numRuns * (resetCycles + runCycles + 2) + 50;

  logic clk;
  logic reset;
  logic button;
  logic loadEnable;
  logic [5:0] loadAddress;
  logic [cpuPkg::xlen-1:0] loadData;
  logic [cpuPkg::ledWidth-1:0] debug;

  logic [31:0] image [$];
  logic [31:0] lcgState;
  int errors;
  int checks;
  int cycleCount;

  cpu #(
    .instrDepth(64),
    .dataDepth(64)
  ) dut_i (
    .clk(clk),
    .reset(reset),
    .button(button),
    .loadEnable(loadEnable),
    .loadAddress(loadAddress),
    .loadData(loadData),
    .debug(debug)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycleCount = 0;
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= timeoutLimit) begin
      $display("Timeout: the run hung after %0d cycles", cycleCount);
      $display("Test failed");
      $finish;
    end
  end

  // Instruction encoders
  function automatic logic [31:0] rOp(input string name, input int rd, input int rs1,
                                      input int rs2);
    logic [6:0] funct7;
    logic [2:0] funct3;
    funct7 = (name == "sub") ? 7'b0100000 : 7'b0000000;
    case (name)
      "slt": funct3 = 3'b010;
      "xor": funct3 = 3'b100;
      "or": funct3 = 3'b110;
      "and": funct3 = 3'b111;
      default: funct3 = 3'b000;
    endcase
    return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] auipc(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'b0010111};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branchOp(input logic notEqual, input int rs1, input int rs2,
                                           input int offset);
    logic [12:0] imm;
    imm = offset[12:0];
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 2'b00, notEqual, imm[4:1], imm[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  task automatic emit(input logic [31:0] word);
    image.push_back(word);
  endtask

  task automatic checkLed(input string testName, input logic [cpuPkg::ledWidth-1:0] expected,
                          input logic [cpuPkg::ledWidth-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", testName, expected, actual);
    end
  endtask

  // Zero words past the image decode as no-ops
  task automatic runProgram(input string testName, input logic [cpuPkg::ledWidth-1:0] expected);
    int i;
    reset = 1'b1;
    for (i = 0; i < resetCycles; i++) begin
      loadEnable = 1'b1;
      loadAddress = i[5:0];
      loadData = (i < image.size()) ? image[i] : 32'h0;
      @(posedge clk);
      #2;
    end
    loadEnable = 1'b0;
    reset = 1'b0;
    checkLed({testName, " after reset"}, '0, debug);
    repeat (runCycles) @(posedge clk);
    #2;
    checkLed(testName, expected, debug);
  endtask

  task automatic aluChainTest();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    logic [31:0] r6;
    logic [31:0] r7;
    logic [31:0] r8;
    image.delete();
    emit(addi(10, 0, 256));
    emit(addi(1, 0, 45));
    emit(addi(2, 0, -19));
    emit(rOp("add", 3, 1, 2));
    emit(rOp("sub", 4, 3, 2));
    emit(rOp("xor", 5, 4, 3));
    emit(rOp("and", 6, 5, 4));
    emit(rOp("or", 7, 6, 5));
    emit(sw(7, 10, 0));
    emit(rOp("add", 8, 7, 6));
    emit(sw(8, 10, 0));
    emit(branchOp(1'b0, 0, 0, 0));
    r1 = 32'd45;
    r2 = 32'd0 - 32'd19;
    r3 = r1 + r2;
    r4 = r3 - r2;
    r5 = r4 ^ r3;
    r6 = r5 & r4;
    r7 = r6 | r5;
    r8 = r7 + r6;
    runProgram("aluChain", r8[cpuPkg::ledWidth-1:0]);
  endtask

  task automatic upperImmTest();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r5;
    logic [31:0] r9;
    image.delete();
    emit(addi(10, 0, 256));
    emit(lui(9, 'hFFFFF));
    emit(addi(1, 9, 2047));
    emit(rOp("slt", 2, 1, 10));
    emit(auipc(3, 1));
    emit(rOp("add", 4, 3, 2));
    emit(rOp("xor", 5, 4, 1));
    emit(sw(5, 10, 0));
    emit(branchOp(1'b0, 0, 0, 0));
    r9 = 32'hFFFF_F000;
    r1 = r9 + 32'd2047;
    r2 = ($signed(r1) < $signed(32'd256)) ? 32'd1 : 32'd0;
    // AUIPC sits at word 4
    r3 = 32'd16 + 32'h0000_1000;
    r5 = (r3 + r2) ^ r1;
    runProgram("upperImm", r5[cpuPkg::ledWidth-1:0]);
  endtask

  task automatic loadUseTest();
    image.delete();
    emit(addi(10, 0, 256));
    emit(addi(1, 0, 23));
    emit(sw(1, 0, 8));
    emit(lw(2, 0, 8));
    emit(rOp("add", 3, 2, 1));
    emit(sw(3, 10, 0));
    emit(branchOp(1'b0, 0, 0, 0));
    runProgram("loadUse", 6'd46);
  endtask

  task automatic branchTest();
    image.delete();
    emit(addi(10, 0, 256));
    emit(addi(1, 0, 5));
    emit(addi(2, 0, 6));
    emit(addi(3, 0, 33));
    emit(addi(4, 0, 12));
    emit(branchOp(1'b0, 1, 2, 8));
    emit(sw(4, 10, 0));
    emit(branchOp(1'b0, 1, 1, 8));
    emit(sw(3, 10, 0));
    emit(branchOp(1'b1, 1, 2, 8));
    emit(sw(3, 10, 0));
    emit(branchOp(1'b0, 0, 0, 0));
    runProgram("branches", 6'd12);
  endtask

  task automatic buttonTest();
    int level;
    for (level = 0; level < 2; level++) begin
      button = level[0];
      image.delete();
      emit(addi(10, 0, 256));
      emit(lw(1, 0, 260));
      emit(addi(2, 1, 40));
      emit(sw(2, 10, 0));
      emit(branchOp(1'b0, 0, 0, 0));
      runProgram($sformatf("button%0d", level), 6'(40 + level));
    end
    button = 1'b0;
  endtask

  task automatic randomTest();
    int round;
    logic [31:0] word;
    logic [31:0] immA;
    logic [31:0] immB;
    logic [31:0] immC;
    logic [31:0] result;
    for (round = 0; round < 3; round++) begin
      word = nextRandom();
      immA = {{20{word[27]}}, word[27:16]};
      word = nextRandom();
      immB = {{20{word[27]}}, word[27:16]};
      word = nextRandom();
      immC = {{20{word[27]}}, word[27:16]};
      image.delete();
      emit(addi(10, 0, 256));
      emit(addi(1, 0, immA));
      emit(addi(2, 1, immB));
      emit(addi(4, 0, immC));
      emit(rOp("add", 3, 2, 1));
      emit(rOp("xor", 5, 3, 4));
      emit(sw(5, 10, 0));
      emit(branchOp(1'b0, 0, 0, 0));
      result = ((immA + immB) + immA) ^ immC;
      runProgram($sformatf("random%0d", round), result[cpuPkg::ledWidth-1:0]);
    end
  endtask

  initial begin
    reset = 1'b1;
    button = 1'b0;
    loadEnable = 1'b0;
    loadAddress = '0;
    loadData = '0;
    errors = 0;
    checks = 0;
    lcgState = 32'd70;
    @(posedge clk);
    #2;
    aluChainTest();
    upperImmTest();
    loadUseTest();
    branchTest();
    buttonTest();
    randomTest();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu #(
  parameter int instrDepth = 64,
  parameter int dataDepth = 64
) (
  input wire clk,
  input wire reset,
  input wire button,
  input wire loadEnable,
  input wire [$clog2(instrDepth)-1:0] loadAddress,
  input wire [cpuPkg::xlen-1:0] loadData,
  output logic [cpuPkg::ledWidth-1:0] debug
);

  logic [cpuPkg::xlen-1:0] pc;
  logic [cpuPkg::xlen-1:0] fetchInstruction;
  cpuPkg::ifIdPayload ifIdIn;
  cpuPkg::ifIdPayload ifIdOut;

  logic [cpuPkg::regIndexWidth-1:0] decodeLhsIndex;
  logic [cpuPkg::regIndexWidth-1:0] decodeRhsIndex;
  logic [cpuPkg::xlen-1:0] decodeLhsValue;
  logic [cpuPkg::xlen-1:0] decodeRhsValue;
  logic [cpuPkg::xlen-1:0] decodeImmediate;
  cpuPkg::aluOp decodeAluOp;
  logic decodeAluSrc;
  logic decodePcToAlu;
  logic decodeBranch;
  logic decodeBranchNotEqual;
  logic decodeMemRead;
  logic decodeMemWrite;
  logic decodeMemToReg;
  logic decodeRegWrite;
  logic stall;
  cpuPkg::idExPayload idExIn;
  cpuPkg::idExPayload idExOut;

  cpuPkg::forwardSel lhsForward;
  cpuPkg::forwardSel rhsForward;
  logic [cpuPkg::xlen-1:0] aluResult;
  logic [cpuPkg::xlen-1:0] storeData;
  logic [cpuPkg::xlen-1:0] branchTarget;
  logic takeBranch;
  cpuPkg::exMemPayload exMemIn;
  cpuPkg::exMemPayload exMemOut;

  logic [cpuPkg::xlen-1:0] memoryData;
  cpuPkg::memWbPayload memWbIn;
  cpuPkg::memWbPayload memWbOut;
  logic [cpuPkg::xlen-1:0] writebackData;

  // Fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (takeBranch) begin
      pc <= branchTarget;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  assign ifIdIn = '{instruction: fetchInstruction, pc: pc};

  pipelineBarrier #(.payloadType(cpuPkg::ifIdPayload)) ifId (
    .clk(clk),
    .reset(reset),
    .flush(takeBranch),
    .hold(stall),
    .dataIn(ifIdIn),
    .dataOut(ifIdOut)
  );

  // Decode
  assign decodeLhsIndex = ifIdOut.instruction[19:15];
  assign decodeRhsIndex = ifIdOut.instruction[24:20];

  decoder decoder_i (
    .instruction(ifIdOut.instruction),
    .aluOp(decodeAluOp),
    .aluSrc(decodeAluSrc),
    .pcToAlu(decodePcToAlu),
    .branch(decodeBranch),
    .branchNotEqual(decodeBranchNotEqual),
    .memRead(decodeMemRead),
    .memWrite(decodeMemWrite),
    .memToReg(decodeMemToReg),
    .regWrite(decodeRegWrite),
    .immediate(decodeImmediate)
  );

  registerFile registerFile_i (
    .clk(clk),
    .reset(reset),
    .readIndexA(decodeLhsIndex),
    .readIndexB(decodeRhsIndex),
    .writeIndex(memWbOut.writeIndex),
    .writeData(writebackData),
    .writeEnable(memWbOut.regWrite),
    .readDataA(decodeLhsValue),
    .readDataB(decodeRhsValue)
  );

  hazardUnit hazardUnit_i (
    .decodeLhsIndex(decodeLhsIndex),
    .decodeRhsIndex(decodeRhsIndex),
    .executeWriteIndex(idExOut.writeIndex),
    .executeMemRead(idExOut.memRead),
    .executeLhsIndex(idExOut.lhsIndex),
    .executeRhsIndex(idExOut.rhsIndex),
    .memoryWriteIndex(exMemOut.writeIndex),
    .memoryRegWrite(exMemOut.regWrite),
    .writebackWriteIndex(memWbOut.writeIndex),
    .writebackRegWrite(memWbOut.regWrite),
    .stall(stall),
    .lhsForward(lhsForward),
    .rhsForward(rhsForward)
  );

  // Controls stay zero on a stall, which sends a bubble into execute
  always_comb begin
    idExIn = '0;
    idExIn.pc = ifIdOut.pc;
    idExIn.lhsValue = decodeLhsValue;
    idExIn.rhsValue = decodeRhsValue;
    idExIn.lhsIndex = decodeLhsIndex;
    idExIn.rhsIndex = decodeRhsIndex;
    idExIn.writeIndex = ifIdOut.instruction[11:7];
    idExIn.immediate = decodeImmediate;
    if (!stall) begin
      idExIn.aluOp = decodeAluOp;
      idExIn.aluSrc = decodeAluSrc;
      idExIn.pcToAlu = decodePcToAlu;
      idExIn.branch = decodeBranch;
      idExIn.branchNotEqual = decodeBranchNotEqual;
      idExIn.memRead = decodeMemRead;
      idExIn.memWrite = decodeMemWrite;
      idExIn.memToReg = decodeMemToReg;
      idExIn.regWrite = decodeRegWrite;
    end
  end

  pipelineBarrier #(.payloadType(cpuPkg::idExPayload)) idEx (
    .clk(clk),
    .reset(reset),
    .flush(takeBranch),
    .hold(1'b0),
    .dataIn(idExIn),
    .dataOut(idExOut)
  );

  // Execute
  executeUnit executeUnit_i (
    .payload(idExOut),
    .lhsForward(lhsForward),
    .rhsForward(rhsForward),
    .memoryResult(exMemOut.aluResult),
    .writebackResult(writebackData),
    .aluResult(aluResult),
    .storeData(storeData),
    .branchTarget(branchTarget),
    .takeBranch(takeBranch)
  );

  assign exMemIn = '{
    aluResult: aluResult,
    storeData: storeData,
    writeIndex: idExOut.writeIndex,
    memRead: idExOut.memRead,
    memWrite: idExOut.memWrite,
    memToReg: idExOut.memToReg,
    regWrite: idExOut.regWrite
  };

  pipelineBarrier #(.payloadType(cpuPkg::exMemPayload)) exMem (
    .clk(clk),
    .reset(reset),
    .flush(1'b0),
    .hold(1'b0),
    .dataIn(exMemIn),
    .dataOut(exMemOut)
  );

  // Memory
  memoryUnit #(
    .instrDepth(instrDepth),
    .dataDepth(dataDepth)
  ) memoryUnit_i (
    .clk(clk),
    .reset(reset),
    .loadEnable(loadEnable),
    .loadAddress(loadAddress),
    .loadData(loadData),
    .instrAddress(pc),
    .dataRead(exMemOut.memRead),
    .dataWrite(exMemOut.memWrite),
    .dataAddress(exMemOut.aluResult),
    .dataWriteData(exMemOut.storeData),
    .button(button),
    .instruction(fetchInstruction),
    .dataReadData(memoryData),
    .debug(debug)
  );

  assign memWbIn = '{
    memoryData: memoryData,
    aluResult: exMemOut.aluResult,
    writeIndex: exMemOut.writeIndex,
    memToReg: exMemOut.memToReg,
    regWrite: exMemOut.regWrite
  };

  pipelineBarrier #(.payloadType(cpuPkg::memWbPayload)) memWb (
    .clk(clk),
    .reset(reset),
    .flush(1'b0),
    .hold(1'b0),
    .dataIn(memWbIn),
    .dataOut(memWbOut)
  );

  // Writeback
  assign writebackData = memWbOut.memToReg ? memWbOut.memoryData : memWbOut.aluResult;

endmodule

`default_nettype wire

/* logic/memoryUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryUnit #(
  parameter int instrDepth = 64,
  parameter int dataDepth = 64
) (
  input wire clk,
  input wire reset,
  input wire loadEnable,
  input wire [$clog2(instrDepth)-1:0] loadAddress,
  input wire [cpuPkg::xlen-1:0] loadData,
  input wire [cpuPkg::xlen-1:0] instrAddress,
  input wire dataRead,
  input wire dataWrite,
  input wire [cpuPkg::xlen-1:0] dataAddress,
  input wire [cpuPkg::xlen-1:0] dataWriteData,
  input wire button,
  output logic [cpuPkg::xlen-1:0] instruction,
  output logic [cpuPkg::xlen-1:0] dataReadData,
  output logic [cpuPkg::ledWidth-1:0] debug
);

  localparam int instrIndexWidth = $clog2(instrDepth);
  localparam int dataIndexWidth = $clog2(dataDepth);

  logic [cpuPkg::xlen-1:0] instrStore [instrDepth];
  logic [cpuPkg::xlen-1:0] dataStore [dataDepth];
  logic isLed;
  logic isButton;

  assign isLed = dataAddress == cpuPkg::ledAddress;
  assign isButton = dataAddress == cpuPkg::buttonAddress;
  assign instruction = instrStore[instrAddress[2 +: instrIndexWidth]];

  // Loader runs even while the core sits in reset
  always_ff @(posedge clk) begin
    if (loadEnable) begin
      instrStore[loadAddress] <= loadData;
    end
  end

  always_ff @(posedge clk) begin
    if (dataWrite && !isLed && !isButton) begin
      dataStore[dataAddress[2 +: dataIndexWidth]] <= dataWriteData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      debug <= '0;
    end else if (dataWrite && isLed) begin
      debug <= dataWriteData[cpuPkg::ledWidth-1:0];
    end
  end

  always_comb begin
    if (!dataRead) begin
      dataReadData = '0;
    end else if (isButton) begin
      dataReadData = {{(cpuPkg::xlen-1){1'b0}}, button};
    end else begin
      dataReadData = dataStore[dataAddress[2 +: dataIndexWidth]];
    end
  end

endmodule

`default_nettype wire

/* logic/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
  input wire cpuPkg::idExPayload payload,
  input wire cpuPkg::forwardSel lhsForward,
  input wire cpuPkg::forwardSel rhsForward,
  input wire [cpuPkg::xlen-1:0] memoryResult,
  input wire [cpuPkg::xlen-1:0] writebackResult,
  output logic [cpuPkg::xlen-1:0] aluResult,
  output logic [cpuPkg::xlen-1:0] storeData,
  output logic [cpuPkg::xlen-1:0] branchTarget,
  output logic takeBranch
);

  logic [cpuPkg::xlen-1:0] lhsOperand;
  logic [cpuPkg::xlen-1:0] rhsOperand;
  logic [cpuPkg::xlen-1:0] aluLhs;
  logic [cpuPkg::xlen-1:0] aluRhs;

  function automatic logic [cpuPkg::xlen-1:0] pickOperand(
    input cpuPkg::forwardSel sel,
    input logic [cpuPkg::xlen-1:0] registerValue,
    input logic [cpuPkg::xlen-1:0] memValue,
    input logic [cpuPkg::xlen-1:0] wbValue
  );
    case (sel)
      cpuPkg::fwdMem: return memValue;
      cpuPkg::fwdWb: return wbValue;
      default: return registerValue;
    endcase
  endfunction

  always_comb begin
    lhsOperand = pickOperand(lhsForward, payload.lhsValue, memoryResult, writebackResult);
    rhsOperand = pickOperand(rhsForward, payload.rhsValue, memoryResult, writebackResult);
    // AUIPC takes pc, immediates replace rhs
    aluLhs = payload.pcToAlu ? payload.pc : lhsOperand;
    aluRhs = payload.aluSrc ? payload.immediate : rhsOperand;

    case (payload.aluOp)
      cpuPkg::aluSub: aluResult = aluLhs - aluRhs;
      cpuPkg::aluAnd: aluResult = aluLhs & aluRhs;
      cpuPkg::aluOr: aluResult = aluLhs | aluRhs;
      cpuPkg::aluXor: aluResult = aluLhs ^ aluRhs;
      cpuPkg::aluSlt: aluResult = {31'b0, $signed(aluLhs) < $signed(aluRhs)};
      cpuPkg::aluPassB: aluResult = aluRhs;
      default: aluResult = aluLhs + aluRhs;
    endcase

    storeData = rhsOperand;
    takeBranch = payload.branch && ((lhsOperand == rhsOperand) != payload.branchNotEqual);
    branchTarget = payload.pc + payload.immediate;
  end

endmodule

`default_nettype wire

/* logic/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input wire [cpuPkg::xlen-1:0] instruction,
  output cpuPkg::aluOp aluOp,
  output logic aluSrc,
  output logic pcToAlu,
  output logic branch,
  output logic branchNotEqual,
  output logic memRead,
  output logic memWrite,
  output logic memToReg,
  output logic regWrite,
  output logic [cpuPkg::xlen-1:0] immediate
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  // Shared by R and I forms
  function automatic cpuPkg::aluOp arithOp(input logic [2:0] f3, input logic isSub);
    case (f3)
      3'b000: return isSub ? cpuPkg::aluSub : cpuPkg::aluAdd;
      3'b010: return cpuPkg::aluSlt;
      3'b100: return cpuPkg::aluXor;
      3'b110: return cpuPkg::aluOr;
      3'b111: return cpuPkg::aluAnd;
      default: return cpuPkg::aluAdd;
    endcase
  endfunction

  always_comb begin
    aluOp = cpuPkg::aluAdd;
    aluSrc = 1'b0;
    pcToAlu = 1'b0;
    branch = 1'b0;
    branchNotEqual = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    immediate = '0;
    case (opcode)
      cpuPkg::opR: begin
        aluOp = arithOp(funct3, funct7 == 7'b0100000);
        regWrite = 1'b1;
      end
      cpuPkg::opI: begin
        aluOp = arithOp(funct3, 1'b0);
        aluSrc = 1'b1;
        regWrite = 1'b1;
        immediate = {{20{instruction[31]}}, instruction[31:20]};
      end
      cpuPkg::opLui: begin
        aluOp = cpuPkg::aluPassB;
        aluSrc = 1'b1;
        regWrite = 1'b1;
        immediate = {instruction[31:12], 12'b0};
      end
      cpuPkg::opAuipc: begin
        aluSrc = 1'b1;
        pcToAlu = 1'b1;
        regWrite = 1'b1;
        immediate = {instruction[31:12], 12'b0};
      end
      cpuPkg::opLoad: begin
        aluSrc = 1'b1;
        memRead = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        immediate = {{20{instruction[31]}}, instruction[31:20]};
      end
      cpuPkg::opStore: begin
        aluSrc = 1'b1;
        memWrite = 1'b1;
        immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
      end
      cpuPkg::opBranch: begin
        branch = 1'b1;
        // funct3 bit 0 splits BEQ from BNE
        branchNotEqual = funct3[0];
        immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                     instruction[30:25], instruction[11:8], 1'b0};
      end
      default: begin
        regWrite = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
  input wire [cpuPkg::regIndexWidth-1:0] decodeLhsIndex,
  input wire [cpuPkg::regIndexWidth-1:0] decodeRhsIndex,
  input wire [cpuPkg::regIndexWidth-1:0] executeWriteIndex,
  input wire executeMemRead,
  input wire [cpuPkg::regIndexWidth-1:0] executeLhsIndex,
  input wire [cpuPkg::regIndexWidth-1:0] executeRhsIndex,
  input wire [cpuPkg::regIndexWidth-1:0] memoryWriteIndex,
  input wire memoryRegWrite,
  input wire [cpuPkg::regIndexWidth-1:0] writebackWriteIndex,
  input wire writebackRegWrite,
  output logic stall,
  output cpuPkg::forwardSel lhsForward,
  output cpuPkg::forwardSel rhsForward
);

  // Younger producer wins
  function automatic cpuPkg::forwardSel selectSource(
    input logic [cpuPkg::regIndexWidth-1:0] index
  );
    if (memoryRegWrite && memoryWriteIndex != '0 && memoryWriteIndex == index) begin
      return cpuPkg::fwdMem;
    end else if (writebackRegWrite && writebackWriteIndex != '0
                 && writebackWriteIndex == index) begin
      return cpuPkg::fwdWb;
    end
    return cpuPkg::fwdNone;
  endfunction

  always_comb begin
    stall = executeMemRead && executeWriteIndex != '0
            && (executeWriteIndex == decodeLhsIndex || executeWriteIndex == decodeRhsIndex);
    lhsForward = selectSource(executeLhsIndex);
    rhsForward = selectSource(executeRhsIndex);
  end

endmodule

`default_nettype wire

/* logic/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input wire clk,
  input wire reset,
  input wire [cpuPkg::regIndexWidth-1:0] readIndexA,
  input wire [cpuPkg::regIndexWidth-1:0] readIndexB,
  input wire [cpuPkg::regIndexWidth-1:0] writeIndex,
  input wire [cpuPkg::xlen-1:0] writeData,
  input wire writeEnable,
  output logic [cpuPkg::xlen-1:0] readDataA,
  output logic [cpuPkg::xlen-1:0] readDataB
);

  logic [cpuPkg::xlen-1:0] registers [2**cpuPkg::regIndexWidth];

  // Writeback bypass so decode sees the value being written this cycle
  function automatic logic [cpuPkg::xlen-1:0] readPort(
    input logic [cpuPkg::regIndexWidth-1:0] index
  );
    if (index == '0) begin
      return '0;
    end else if (writeEnable && writeIndex == index) begin
      return writeData;
    end
    return registers[index];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      registers <= '{default: '0};
    end else if (writeEnable && writeIndex != '0) begin
      registers[writeIndex] <= writeData;
    end
  end

  always_comb begin
    readDataA = readPort(readIndexA);
    readDataB = readPort(readIndexB);
  end

endmodule

`default_nettype wire

/* logic/pipelineBarrier.sv */
`timescale 1ns/1ps
`default_nettype none

module pipelineBarrier #(
  parameter type payloadType = logic
) (
  input wire clk,
  input wire reset,
  input wire flush,
  input wire hold,
  input wire payloadType dataIn,
  output payloadType dataOut
);

  // Zero payload is a bubble
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      dataOut <= '0;
    end else if (!hold) begin
      dataOut <= dataIn;
    end
  end

endmodule

`default_nettype wire

/* logic/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  localparam int xlen = 32;
  localparam int regIndexWidth = 5;
  localparam int ledWidth = 6;

  // Memory-mapped peripherals
  localparam logic [xlen-1:0] ledAddress = 32'h0000_0100;
  localparam logic [xlen-1:0] buttonAddress = 32'h0000_0104;

  localparam logic [6:0] opR = 7'b0110011;
  localparam logic [6:0] opI = 7'b0010011;
  localparam logic [6:0] opLui = 7'b0110111;
  localparam logic [6:0] opAuipc = 7'b0010111;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;

  // aluAdd must stay at zero so a cleared payload is a no-op
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB
  } aluOp;

  typedef enum logic [1:0] {
    fwdNone,
    fwdMem,
    fwdWb
  } forwardSel;

  typedef struct packed {
    logic [xlen-1:0] instruction;
    logic [xlen-1:0] pc;
  } ifIdPayload;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] lhsValue;
    logic [xlen-1:0] rhsValue;
    logic [regIndexWidth-1:0] lhsIndex;
    logic [regIndexWidth-1:0] rhsIndex;
    logic [regIndexWidth-1:0] writeIndex;
    logic [xlen-1:0] immediate;
    aluOp aluOp;
    logic aluSrc;
    logic pcToAlu;
    logic branch;
    logic branchNotEqual;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;
  } idExPayload;

  typedef struct packed {
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] storeData;
    logic [regIndexWidth-1:0] writeIndex;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;
  } exMemPayload;

  typedef struct packed {
    logic [xlen-1:0] memoryData;
    logic [xlen-1:0] aluResult;
    logic [regIndexWidth-1:0] writeIndex;
    logic memToReg;
    logic regWrite;
  } memWbPayload;

endpackage

`default_nettype wire
